/* hdl/ctrlPkg.sv */
package ctrlPkg;

	localparam int opcodeWidth = 6; // opcode and funct fields

	typedef enum logic [opcodeWidth-1:0] {
		opArith = 6'd0,
		opJ     = 6'd2,
		opJal   = 6'd3,
		opAddi  = 6'd8,
		opAddiu = 6'd9,
		opSlti  = 6'd10,
		opLui   = 6'd15
	} opcode_t;

	typedef enum logic [opcodeWidth-1:0] {
		fnSll  = 6'd0,
		fnSrl  = 6'd2,
		fnSra  = 6'd3,
		fnSllv = 6'd4,
		fnXchg = 6'd5,
		fnSrav = 6'd7,
		fnJr   = 6'd8,
		fnBrk  = 6'd13,
		fnRte  = 6'd19,
		fnAdd  = 6'd32,
		fnSub  = 6'd34,
		fnAnd  = 6'd36,
		fnSlt  = 6'd42
	} funct_t;

	typedef enum logic [4:0] {
		clsAdd, clsSub, clsAnd, clsSlt,
		clsSll, clsSllv, clsSrl, clsSra, clsSrav,
		clsJr, clsXchg, clsBrk, clsRte,
		clsAddi, clsAddiu, clsLui,
		clsJ, clsJal,
		clsIllegal
	} instrClass_t;

	typedef enum logic [4:0] {
		fetchIssue,
		fetchWait,
		fetchLatch,
		decodeIssue,
		decodeWait,
		decodeRead,
		execute,
		exec2,
		exec3,
		exec4
	} state_t;

	typedef enum logic [2:0] {
		aluNone = 3'd0,
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluSlt  = 3'd7
	} aluOp_t;

	typedef enum logic [2:0] {
		shiftNone       = 3'd0,
		shiftLoad       = 3'd1,
		shiftLeft       = 3'd2,
		shiftRightLogic = 3'd3,
		shiftRightArith = 3'd4
	} shiftOp_t;

	typedef enum logic [2:0] {
		pcAluResult  = 3'd0,
		pcEpc        = 3'd2,
		pcJumpTarget = 3'd4
	} pcSource_t;

	typedef enum logic [2:0] {
		dstRt = 3'd0,
		dstRd = 3'd1,
		dstRa = 3'd3, // link register
		dstRs = 3'd4
	} regDst_t;

	typedef enum logic [3:0] {
		srcAluOut   = 4'd0,
		srcLessThan = 4'd4,
		srcShifter  = 4'd5,
		srcRegB     = 4'd6,
		srcRegA     = 4'd7
	} dataSrc_t;

	typedef struct packed {
		logic      pcWrite;
		logic      irWrite;
		logic      aWrite;
		logic      bWrite;
		logic      regWrite;
		logic      aluOutWrite;
		logic      epcWrite;
		logic [1:0] aluSrcA;
		logic [1:0] aluSrcB;
		logic [1:0] shiftSrc;
		logic [1:0] shiftAmt;
		regDst_t   regDst;
		pcSource_t pcSource;
		aluOp_t    aluOp;
		shiftOp_t  shiftOp;
		dataSrc_t  dataSrc;
		logic      reserved; // pads to 32 bits, always 0
	} ctrlWord_t;

endpackage

/* hdl/instrDecode.sv */
`timescale 1ns/100ps

module instrDecode import ctrlPkg::*; (
	input  opcode_t     opcode,
	input  funct_t      funct,
	output instrClass_t instrClass
);

	instrClass_t rClass;

	// R-type, selected by funct
	always_comb begin
		case (funct)
			fnAdd:   rClass = clsAdd;
			fnSub:   rClass = clsSub;
			fnAnd:   rClass = clsAnd;
			fnSlt:   rClass = clsSlt;
			fnSll:   rClass = clsSll;
			fnSllv:  rClass = clsSllv;
			fnSrl:   rClass = clsSrl;
			fnSra:   rClass = clsSra;
			fnSrav:  rClass = clsSrav;
			fnJr:    rClass = clsJr;
			fnXchg:  rClass = clsXchg;
			fnBrk:   rClass = clsBrk;
			fnRte:   rClass = clsRte;
			default: rClass = clsIllegal;
		endcase
	end

	always_comb begin
		case (opcode)
			opArith: instrClass = rClass;
			opAddi:  instrClass = clsAddi;
			opAddiu: instrClass = clsAddiu;
			opLui:   instrClass = clsLui;
			opJ:     instrClass = clsJ;
			opJal:   instrClass = clsJal;
			opSlti:  instrClass = clsIllegal; // no slti sequence
			default: instrClass = clsIllegal;
		endcase
	end

endmodule

/* hdl/stateSequencer.sv */
`timescale 1ns/100ps

module stateSequencer import ctrlPkg::*; #(
	parameter int memWaitCycles = 2
) (
	input  logic        clk,
	input  logic        reset,
	input  instrClass_t instrClass,
	output state_t      state
);

	localparam int cntWidth = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;

	logic [cntWidth-1:0] waitCnt;
	logic                waitLast;
	state_t              nextState;

	assign waitLast = (waitCnt == cntWidth'(memWaitCycles - 1));

	always_comb begin
		case (state)
			fetchIssue:  nextState = (memWaitCycles == 0) ? fetchLatch : fetchWait;
			fetchWait:   nextState = waitLast ? fetchLatch : fetchWait;
			fetchLatch:  nextState = decodeIssue;
			decodeIssue: nextState = decodeWait;
			decodeWait:  nextState = decodeRead;
			decodeRead:  nextState = execute;
			execute: begin
				case (instrClass)
					clsRte, clsJr, clsJ, clsJal, clsIllegal: nextState = fetchIssue;
					default: nextState = exec2;
				endcase
			end
			exec2: begin
				if (instrClass inside {clsBrk, clsSlt}) begin
					nextState = fetchIssue;
				end else begin
					nextState = exec3;
				end
			end
			default: nextState = fetchIssue; // exec3, exec4
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetchIssue;
			waitCnt <= '0;
		end else begin
			state <= nextState;
			if (state == fetchWait) begin
				waitCnt <= waitCnt + 1'b1;
			end else begin
				waitCnt <= '0;
			end
		end
	end

	stateLegal: assert property (@(posedge clk) disable iff (reset)
		state inside {fetchIssue, fetchWait, fetchLatch, decodeIssue, decodeWait,
			decodeRead, execute, exec2, exec3, exec4});

	// single-step classes go straight back to fetch
	shortReturn: assert property (@(posedge clk) disable iff (reset)
		(state == execute && instrClass inside {clsRte, clsJr, clsJ, clsJal, clsIllegal})
		|=> state != exec2);

endmodule

/* hdl/controlEncoder.sv */
`timescale 1ns/100ps

module controlEncoder import ctrlPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  state_t      state,
	input  instrClass_t instrClass,
	output ctrlWord_t   ctrl
);

	ctrlWord_t w;
	logic      immClass;
	regDst_t   writeDst;

	function automatic aluOp_t aluOpOf(instrClass_t cls);
		case (cls)
			clsSub:  return aluSub;
			clsAnd:  return aluAnd;
			clsSlt:  return aluSlt;
			default: return aluAdd;
		endcase
	endfunction

	function automatic shiftOp_t shiftOpOf(instrClass_t cls);
		case (cls)
			clsSrl:       return shiftRightLogic;
			clsSra, clsSrav: return shiftRightArith;
			default:      return shiftLeft;
		endcase
	endfunction

	assign immClass = instrClass inside {clsAddi, clsAddiu};
	assign writeDst = (immClass || instrClass == clsLui) ? dstRt : dstRd;

	always_comb begin
		w = '0;
		// shamt field or constant 16 feeds the shifter
		if (instrClass inside {clsSll, clsSrl, clsSra} && state inside {decodeRead, execute, exec2}) begin
			w.shiftSrc = 2'b10;
			w.shiftAmt = 2'b10;
		end
		if (instrClass == clsLui && state inside {decodeRead, execute, exec2, exec3}) begin
			w.shiftSrc = 2'b01;
			w.shiftAmt = 2'b01;
		end
		case (state)
			fetchIssue, fetchWait, fetchLatch: begin
				w.irWrite = 1'b1;
				w.aluSrcB = 2'b01; // pc + 4
				w.aluOp = aluAdd;
				w.pcWrite = (state == fetchLatch);
				w.epcWrite = (state == fetchLatch);
			end
			decodeIssue, decodeWait: begin
				w.aluSrcB = 2'b11; // branch target
				w.aluOp = aluAdd;
				w.aluOutWrite = (state == decodeWait);
				w.aWrite = (state == decodeWait);
				w.bWrite = (state == decodeWait);
			end
			decodeRead: begin
				case (instrClass)
					clsAdd, clsSub, clsAnd, clsSlt, clsAddi, clsAddiu: begin
						w.aluSrcA = 2'b01;
						w.aluSrcB = immClass ? 2'b10 : 2'b00;
						w.aluOp = aluOpOf(instrClass);
					end
					clsBrk: begin
						w.aluSrcB = 2'b01;
						w.aluOp = aluSub; // back to faulting pc
					end
					clsRte: begin
						w.pcWrite = 1'b1;
						w.pcSource = pcEpc;
					end
					clsJr: begin
						w.pcWrite = 1'b1;
						w.aluSrcA = 2'b01;
					end
					clsXchg: begin
						w.regWrite = 1'b1;
						w.regDst = dstRs;
						w.dataSrc = srcRegA;
					end
					clsJ, clsJal: begin
						w.pcWrite = 1'b1;
						w.pcSource = pcJumpTarget;
						w.regWrite = (instrClass == clsJal);
						w.aluOutWrite = (instrClass == clsJal);
						w.regDst = (instrClass == clsJal) ? dstRa : dstRt;
					end
					default: ;
				endcase
			end
			execute: begin
				case (instrClass)
					clsAdd, clsSub, clsAnd, clsAddi, clsAddiu: begin
						w.aluOutWrite = 1'b1;
						w.aluSrcA = 2'b01;
						w.aluSrcB = immClass ? 2'b10 : 2'b00;
						w.aluOp = aluOpOf(instrClass);
						w.regDst = writeDst;
					end
					clsSlt: begin
						w.regWrite = 1'b1;
						w.aluSrcA = 2'b01;
						w.aluOp = aluSlt;
						w.regDst = dstRd;
						w.dataSrc = srcLessThan;
					end
					clsBrk: begin
						w.pcWrite = 1'b1;
						w.aluSrcB = 2'b01;
						w.aluOp = aluSub;
					end
					clsRte: begin
						w.pcWrite = 1'b1;
						w.pcSource = pcEpc;
					end
					clsSll, clsSllv, clsSrl, clsSra, clsSrav, clsLui: w.shiftOp = shiftLoad;
					clsJr: w.aluSrcA = 2'b01;
					clsXchg: begin
						w.aluSrcA = 2'b01;
						w.regDst = dstRs;
						w.dataSrc = srcRegA;
					end
					clsJ, clsJal: begin
						w.pcSource = pcJumpTarget;
						w.regDst = (instrClass == clsJal) ? dstRa : dstRt;
					end
					default: ;
				endcase
			end
			exec2: begin
				case (instrClass)
					clsAdd, clsSub, clsAnd: w.regDst = dstRd;
					clsSlt: begin
						w.aluSrcA = 2'b01;
						w.aluOp = aluSlt;
						w.regDst = dstRd;
						w.dataSrc = srcLessThan;
					end
					clsBrk: w.aluOp = aluSub;
					clsSll, clsSllv, clsSrl, clsSra, clsSrav, clsLui: begin
						w.shiftOp = shiftOpOf(instrClass);
						w.regDst = writeDst;
						w.dataSrc = srcShifter;
					end
					clsXchg: begin
						w.regWrite = 1'b1; // second half of the swap
						w.aluSrcA = 2'b01;
						w.regDst = dstRt;
						w.dataSrc = srcRegB;
					end
					default: ;
				endcase
			end
			exec3: begin
				case (instrClass)
					clsAdd, clsSub, clsAnd, clsAddi, clsAddiu: begin
						w.regWrite = 1'b1;
						w.regDst = writeDst;
					end
					clsSll, clsSllv, clsSrl, clsSra, clsSrav, clsLui: begin
						w.regWrite = 1'b1;
						w.regDst = writeDst;
						w.dataSrc = srcShifter;
					end
					clsXchg: begin
						w.aluSrcA = 2'b01;
						w.dataSrc = srcRegB;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			ctrl <= w;
		end
	end

	irAfterFetch: assert property (@(posedge clk) disable iff (reset)
		ctrl.irWrite |-> $past(state) inside {fetchIssue, fetchWait, fetchLatch});

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit import ctrlPkg::*; #(
	parameter int memWaitCycles = 2
) (
	input  logic      clk,
	input  logic      reset,
	input  opcode_t   opcode,
	input  funct_t    funct,
	output state_t    state,
	output ctrlWord_t ctrl
);

	instrClass_t instrClass;

	instrDecode instrDecode_inst (
		.opcode     (opcode),
		.funct      (funct),
		.instrClass (instrClass)
	);

	stateSequencer #(
		.memWaitCycles (memWaitCycles)
	) stateSequencer_inst (
		.clk        (clk),
		.reset      (reset),
		.instrClass (instrClass),
		.state      (state)
	);

	// word for the current state shows up one cycle later
	controlEncoder controlEncoder_inst (
		.clk        (clk),
		.reset      (reset),
		.state      (state),
		.instrClass (instrClass),
		.ctrl       (ctrl)
	);

endmodule

/* dv/controlChecks.svh */
task automatic compareState(input string name, input state_t exp, input state_t act);
	if (exp !== act) begin
		$display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
		errorCount++;
	end
endtask

task automatic compareCtrlField(input string field, input ctrlWord_t exp, input ctrlWord_t act);
	logic [3:0] e;
	logic [3:0] a;
	if (field == "regDst") begin
		e = 4'(exp.regDst);
		a = 4'(act.regDst);
	end else if (field == "pcSource") begin
		e = 4'(exp.pcSource);
		a = 4'(act.pcSource);
	end else if (field == "aluOp") begin
		e = 4'(exp.aluOp);
		a = 4'(act.aluOp);
	end else if (field == "shiftOp") begin
		e = 4'(exp.shiftOp);
		a = 4'(act.shiftOp);
	end else if (field == "dataSrc") begin
		e = exp.dataSrc;
		a = act.dataSrc;
	end else begin
		$display("check asked for a control field that does not exist: %s", field);
		errorCount++;
		e = '0;
		a = '0;
	end
	if (e !== a) begin
		$display("** Error at %0t: ctrl.%s expected %0d, got %0d", $time, field, e, a);
		errorCount++;
	end
endtask

task automatic compareBit(input string name, input bit exp, input bit act);
	if (exp !== act) begin
		$display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
		errorCount++;
	end
endtask

task automatic compareCount(input string name, input int exp, input int act);
	if (exp != act) begin
		$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		errorCount++;
	end
endtask

// cycles from execute back to fetch
function automatic int execSteps(instrClass_t cls);
	if (cls inside {clsRte, clsJr, clsJ, clsJal, clsIllegal}) return 1;
	if (cls inside {clsBrk, clsSlt}) return 2;
	return 3;
endfunction

function automatic int regWriteCount(instrClass_t cls);
	if (cls == clsXchg) return 2;
	if (cls inside {clsBrk, clsRte, clsJr, clsJ, clsIllegal}) return 0;
	return 1;
endfunction

function automatic ctrlWord_t regWriteWord(instrClass_t cls, int idx);
	ctrlWord_t w;
	w = '0;
	w.regDst = (cls inside {clsAddi, clsAddiu, clsLui}) ? dstRt : dstRd;
	if (cls inside {clsSll, clsSllv, clsSrl, clsSra, clsSrav, clsLui}) w.dataSrc = srcShifter;
	if (cls == clsSlt) w.dataSrc = srcLessThan;
	if (cls == clsJal) w.regDst = dstRa;
	if (cls == clsXchg) begin
		w.regDst = (idx == 0) ? dstRs : dstRt; // swap goes rs first
		w.dataSrc = (idx == 0) ? srcRegA : srcRegB;
	end
	return w;
endfunction

function automatic int pcWriteCount(instrClass_t cls);
	if (cls == clsRte) return 2;
	if (cls inside {clsJ, clsJal, clsJr, clsBrk}) return 1;
	return 0;
endfunction

function automatic pcSource_t pcRule(instrClass_t cls);
	if (cls inside {clsJ, clsJal}) return pcJumpTarget;
	if (cls == clsRte) return pcEpc;
	return pcAluResult;
endfunction

function automatic aluOp_t aluRule(instrClass_t cls);
	case (cls)
		clsAdd:  return aluAdd;
		clsSub:  return aluSub;
		clsAnd:  return aluAnd;
		clsSlt:  return aluSlt;
		default: return aluNone; // not checked
	endcase
endfunction

function automatic shiftOp_t shiftRule(instrClass_t cls);
	case (cls)
		clsSll, clsSllv, clsLui: return shiftLeft;
		clsSrl:                  return shiftRightLogic;
		clsSra, clsSrav:         return shiftRightArith;
		default:                 return shiftNone;
	endcase
endfunction

/* dv/controlUnitTb.sv */
`timescale 1ns/100ps

module controlUnitTb import ctrlPkg::*; ();

	localparam int memWaitCycles = 2;
	localparam int timeoutCycles = 40;

	logic      clk;
	logic      reset;
	opcode_t   opcode;
	funct_t    funct;
	state_t    state;
	ctrlWord_t ctrl;

	int errorCount;
	int passCount;
	int failCount;
	bit hung;

	controlUnit #(
		.memWaitCycles (memWaitCycles)
	) controlUnit_inst (
		.clk    (clk),
		.reset  (reset),
		.opcode (opcode),
		.funct  (funct),
		.state  (state),
		.ctrl   (ctrl)
	);

	`include "controlChecks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic nextCycle();
		@(posedge clk);
		#10; // drive and sample point
	endtask

	task automatic waitForState(input state_t target);
		int n;
		n = 0;
		while (state != target && !hung) begin
			nextCycle();
			n++;
			if (n >= timeoutCycles) begin
				$display("timeout: state %s not reached in %0d cycles", target.name(), n);
				hung = 1'b1;
			end
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errorCount == errBefore && !hung) begin
			passCount++;
			$display("test %s: pass", name);
		end else begin
			failCount++;
			$display("test %s: fail", name);
		end
	endtask

	function automatic opcode_t randomIllegalOpcode();
		logic [5:0] r;
		r = 6'($urandom);
		for (int i = 0; i < 64 && (r inside {6'd0, 6'd2, 6'd3, 6'd8, 6'd9, 6'd15}); i++) begin
			r = 6'($urandom);
		end
		if (r inside {6'd0, 6'd2, 6'd3, 6'd8, 6'd9, 6'd15}) r = 6'h3f;
		return opcode_t'(r);
	endfunction

	task automatic testResetFetch();
		state_t    expSeq[$];
		state_t    prev;
		ctrlWord_t expWord;
		int        irCount;
		int        pcCount;
		int        errBefore;
		errBefore = errorCount;
		expSeq.push_back(fetchIssue);
		repeat (memWaitCycles) expSeq.push_back(fetchWait);
		expSeq.push_back(fetchLatch);
		expSeq.push_back(decodeIssue);
		expSeq.push_back(decodeWait);
		expSeq.push_back(decodeRead);
		expSeq.push_back(execute);
		expWord = '0;
		irCount = 0;
		pcCount = 0;
		opcode = opAddi; // no pc write during decode
		funct = fnSll;
		reset = 1'b1;
		repeat (10) nextCycle();
		reset = 1'b0;
		compareState("state", fetchIssue, state);
		compareBit("ctrl all zero", 1'b1, ctrl == '0);
		for (int i = 1; i <= expSeq.size(); i++) begin
			prev = state;
			nextCycle();
			if (i < expSeq.size()) compareState("state", expSeq[i], state);
			compareBit("irWrite", prev inside {fetchIssue, fetchWait, fetchLatch}, ctrl.irWrite);
			compareBit("pcWrite", prev == fetchLatch, ctrl.pcWrite);
			compareBit("epcWrite", prev == fetchLatch, ctrl.epcWrite);
			if (ctrl.pcWrite) compareCtrlField("pcSource", expWord, ctrl);
			if (ctrl.irWrite) irCount++;
			if (ctrl.pcWrite) pcCount++;
		end
		compareCount("irWrite cycles", memWaitCycles + 2, irCount);
		compareCount("fetch pcWrite pulses", 1, pcCount);
		waitForState(fetchIssue);
		reportTest("reset and fetch", errBefore);
	endtask

	// one full instruction, checked against the per-class rules
	task automatic testInstr(input string name, input opcode_t op, input funct_t fn,
		input instrClass_t cls);
		state_t    prev;
		ctrlWord_t regWrites[$];
		ctrlWord_t pcWrites[$];
		ctrlWord_t shifts[$];
		ctrlWord_t expWord;
		int        execLen;
		int        n;
		int        errBefore;
		errBefore = errorCount;
		if (hung) return;
		waitForState(fetchIssue);
		opcode = op;
		funct = fn;
		prev = state;
		execLen = 0;
		n = 0;
		while (!hung) begin
			nextCycle();
			n++;
			if (ctrl.regWrite) regWrites.push_back(ctrl);
			if (ctrl.pcWrite && !(prev inside {fetchIssue, fetchWait, fetchLatch})) begin
				pcWrites.push_back(ctrl);
			end
			if (ctrl.shiftOp != shiftNone) shifts.push_back(ctrl);
			if (prev == execute && aluRule(cls) != aluNone) begin
				expWord = '0;
				expWord.aluOp = aluRule(cls);
				compareCtrlField("aluOp", expWord, ctrl);
			end
			if (state inside {execute, exec2, exec3, exec4}) execLen++;
			if (state == fetchIssue) break;
			if (n >= timeoutCycles) begin
				$display("timeout: %s did not return to fetch in %0d cycles", name, n);
				hung = 1'b1;
			end
			prev = state;
		end
		if (hung) return;
		compareCount("cycles from execute to fetch", execSteps(cls), execLen);
		compareCount("regWrite cycles", regWriteCount(cls), regWrites.size());
		foreach (regWrites[i]) begin
			if (i < regWriteCount(cls)) begin
				compareCtrlField("regDst", regWriteWord(cls, i), regWrites[i]);
				if (cls != clsJal) compareCtrlField("dataSrc", regWriteWord(cls, i), regWrites[i]);
			end
		end
		compareCount("pcWrite cycles after decode", pcWriteCount(cls), pcWrites.size());
		expWord = '0;
		expWord.pcSource = pcRule(cls);
		foreach (pcWrites[i]) compareCtrlField("pcSource", expWord, pcWrites[i]);
		compareCount("shift steps", (shiftRule(cls) != shiftNone) ? 2 : 0, shifts.size());
		foreach (shifts[i]) begin
			expWord.shiftOp = (i == 0) ? shiftLoad : shiftRule(cls);
			compareCtrlField("shiftOp", expWord, shifts[i]);
		end
		reportTest(name, errBefore);
	endtask

	initial begin
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		hung = 1'b0;
		reset = 1'b1;
		opcode = opArith;
		funct = fnAdd;
		void'($urandom(32'hee9c_07ee));
		testResetFetch();
		testInstr("add", opArith, fnAdd, clsAdd);
		testInstr("sub", opArith, fnSub, clsSub);
		testInstr("and", opArith, fnAnd, clsAnd);
		testInstr("slt", opArith, fnSlt, clsSlt);
		testInstr("sll", opArith, fnSll, clsSll);
		testInstr("sllv", opArith, fnSllv, clsSllv);
		testInstr("srl", opArith, fnSrl, clsSrl);
		testInstr("sra", opArith, fnSra, clsSra);
		testInstr("srav", opArith, fnSrav, clsSrav);
		testInstr("jr", opArith, fnJr, clsJr);
		testInstr("xchg", opArith, fnXchg, clsXchg);
		testInstr("break", opArith, fnBrk, clsBrk);
		testInstr("rte", opArith, fnRte, clsRte);
		testInstr("addi", opAddi, fnAdd, clsAddi);
		testInstr("addiu", opAddiu, fnAdd, clsAddiu);
		testInstr("lui", opLui, fnAdd, clsLui);
		testInstr("j", opJ, fnAdd, clsJ);
		testInstr("jal", opJal, fnAdd, clsJal);
		testInstr("slti", opSlti, fnAdd, clsIllegal);
		testInstr("random illegal opcode", randomIllegalOpcode(), fnAdd, clsIllegal);
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0 && !hung) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+dv
hdl/ctrlPkg.sv
hdl/instrDecode.sv
hdl/stateSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
dv/controlUnitTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = controlUnitTb
FILELIST = list.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)
